//--- list.f
source/ex_pkg.sv
source/ex_alu.sv
source/ex_mult.sv
source/ex_writeback_ctrl.sv
source/ex_stage.sv
dv/tb_clock_gen.sv
dv/ex_stage_properties.sv
dv/ex_stage_tb.sv

//--- run.sh
#!/bin/sh
# Build and run with Verilator; the run passes only if the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module ex_stage_tb -f list.f -o ex_stage_sim &&
./obj_dir/ex_stage_sim +verilator+error+limit+1000 2>&1 | tee /dev/stderr | grep -qx "NO ERRORS" ||
{ echo "simulation did not pass"; exit 1; }

//--- dv/ex_stage_tb.sv
// Random requests from a fixed-seed LFSR; all ID-side inputs stay put while ex_ready_o is low
`timescale 1ns/1ps
`default_nettype none

module ex_stage_tb;
  import ex_pkg::*;

  localparam int unsigned NUM_TESTS     = 600;
  // Held cycles allowed per request, stalls are forced off after FORCE_AFTER
  localparam int unsigned MAX_HOLD      = 6;
  localparam int unsigned FORCE_AFTER   = 3;
  localparam int unsigned CLK_PERIOD_NS = 8;
  localparam int unsigned SETTLE_NS     = 2;
  localparam int unsigned WATCHDOG_NS   = (NUM_TESTS * (MAX_HOLD + 1) + 32) * CLK_PERIOD_NS;
  localparam logic [31:0] LFSR_SEED     = 32'h639b_0489;
  // x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] LFSR_TAPS     = 32'h8020_0003;

  logic                 clk;
  logic                 rst_n;
  alu_req_t             alu_req;
  mult_req_t            mult_req;
  logic                 csr_access;
  logic                 lsu_en;
  logic [XLEN-1:0]      csr_rdata;
  logic [XLEN-1:0]      lsu_rdata;
  logic                 alu_we;
  logic [RF_ADDR_W-1:0] alu_waddr;
  logic                 wb_we;
  logic [RF_ADDR_W-1:0] wb_waddr;
  logic                 branch_in_ex;
  logic                 lsu_ready_ex;
  logic                 wb_ready;
  rf_port_t             alu_fw;
  rf_port_t             wb_port;
  logic [XLEN-1:0]      jump_target;
  logic                 branch_decision;
  logic                 mult_multicycle;
  logic                 ex_ready;
  logic                 ex_valid;
  logic [31:0]          lfsr_q = LFSR_SEED;

  tb_clock_gen u_clock_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  ex_stage dut (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_req_i           (alu_req),
    .mult_req_i          (mult_req),
    .csr_access_i        (csr_access),
    .lsu_en_i            (lsu_en),
    .csr_rdata_i         (csr_rdata),
    .lsu_rdata_i         (lsu_rdata),
    .regfile_alu_we_i    (alu_we),
    .regfile_alu_waddr_i (alu_waddr),
    .regfile_we_i        (wb_we),
    .regfile_waddr_i     (wb_waddr),
    .branch_in_ex_i      (branch_in_ex),
    .lsu_ready_ex_i      (lsu_ready_ex),
    .wb_ready_i          (wb_ready),
    .regfile_alu_fw_o    (alu_fw),
    .regfile_wb_o        (wb_port),
    .jump_target_o       (jump_target),
    .branch_decision_o   (branch_decision),
    .mult_multicycle_o   (mult_multicycle),
    .ex_ready_o          (ex_ready),
    .ex_valid_o          (ex_valid)
  );

  //////////////////////////////////////////////////
  // Random source
  //////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
  endfunction

  // One LFSR step per bit returned
  function automatic logic [31:0] next_bits(input int unsigned count);
    logic [31:0] value;
    value = '0;
    for (int unsigned i = 0; i < count; i++) begin
      value  = {value[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return value;
  endfunction

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic report_failure(input string reason);
    $display("ERRORS FOUND");
    $fatal(1, "%s", reason);
  endtask

  // LSU and WB readiness, mostly high
  task automatic update_stalls(input logic force_ready);
    logic [31:0] r;
    r = next_bits(5);
    lsu_ready_ex = force_ready | (r[2:0] != 3'b000);
    wb_ready     = force_ready | (r[4:3] != 2'b00);
    lsu_rdata    = next_bits(32);
  endtask

  task automatic drive_request();
    logic [31:0] ctl;
    logic [31:0] dst;
    ctl = next_bits(16);
    dst = next_bits(16);
    alu_req.en        = (ctl[1:0] != 2'b00);
    mult_req.en       = ctl[2];
    csr_access        = (ctl[4:3] == 2'b00);
    lsu_en            = (ctl[6:5] == 2'b00);
    branch_in_ex      = (ctl[9:7] == 3'b000);
    alu_req.op        = alu_op_e'(ctl[13:10]);
    mult_req.op       = mult_op_e'(ctl[15:14]);
    alu_req.operand_a = next_bits(32);
    // Equal operands now and then so EQ and GE get hit
    alu_req.operand_b = (dst[15:14] == 2'b00) ? alu_req.operand_a : next_bits(32);
    alu_req.operand_c = next_bits(32);
    mult_req.operand_a = next_bits(32);
    mult_req.operand_b = next_bits(32);
    csr_rdata         = next_bits(32);
    alu_we            = dst[0];
    alu_waddr         = dst[6:1];
    wb_we             = dst[7];
    wb_waddr          = dst[13:8];
    update_stalls(1'b0);
  endtask

  // Issue on a falling edge, then hold until the stage takes it
  task automatic issue_request();
    int unsigned held;
    held = 0;
    @(negedge clk);
    drive_request();
    #(SETTLE_NS);
    while (!ex_ready) begin
      if (held == MAX_HOLD) begin
        report_failure("ex_ready_o stayed low after the stall inputs were released");
      end
      @(negedge clk);
      update_stalls(held >= FORCE_AFTER);
      held++;
      #(SETTLE_NS);
    end
  endtask

  initial begin
    alu_req      = '0;
    mult_req     = '0;
    csr_access   = 1'b0;
    lsu_en       = 1'b0;
    csr_rdata    = '0;
    lsu_rdata    = '0;
    alu_we       = 1'b0;
    alu_waddr    = '0;
    wb_we        = 1'b0;
    wb_waddr     = '0;
    branch_in_ex = 1'b0;
    lsu_ready_ex = 1'b1;
    wb_ready     = 1'b1;
    wait (rst_n === 1'b1);
    for (int t = 0; t < NUM_TESTS; t++) begin
      issue_request();
    end
    repeat (4) @(negedge clk);
    if (dut.u_props.fail_count == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      report_failure("ex_stage_properties counted failed checks at the end of the run");
    end
  end

  // Checks fire on the rising edge, failures are picked up half a cycle later
  always @(negedge clk) begin
    if (dut.u_props.fail_count != 0) begin
      report_failure("a check in ex_stage_properties failed");
    end
  end

  initial begin
    #(WATCHDOG_NS);
    report_failure("watchdog expired before all requests were issued");
  end

endmodule

`default_nettype wire

//--- dv/ex_stage_properties.sv
// Reference models and checks for ex_stage; assumes ID holds its request while ex_ready_o is low
`timescale 1ns/1ps
`default_nettype none

module ex_stage_properties (
  input logic                         clk,
  input logic                         rst_n,
  input ex_pkg::alu_req_t             alu_req_i,
  input ex_pkg::mult_req_t            mult_req_i,
  input logic                         csr_access_i,
  input logic                         lsu_en_i,
  input logic [ex_pkg::XLEN-1:0]      csr_rdata_i,
  input logic [ex_pkg::XLEN-1:0]      lsu_rdata_i,
  input logic                         regfile_alu_we_i,
  input logic [ex_pkg::RF_ADDR_W-1:0] regfile_alu_waddr_i,
  input logic                         regfile_we_i,
  input logic [ex_pkg::RF_ADDR_W-1:0] regfile_waddr_i,
  input logic                         branch_in_ex_i,
  input logic                         lsu_ready_ex_i,
  input logic                         wb_ready_i,
  input ex_pkg::rf_port_t             regfile_alu_fw_o,
  input ex_pkg::rf_port_t             regfile_wb_o,
  input logic [ex_pkg::XLEN-1:0]      jump_target_o,
  input logic                         branch_decision_o,
  input logic                         mult_multicycle_o,
  input logic                         ex_ready_o,
  input logic                         ex_valid_o
);
  import ex_pkg::*;

  // Count of failed checks that the testbench polls
  int unsigned          fail_count = 0;

  // ALU reference
  logic [XLEN-1:0]      alu_a;
  logic [XLEN-1:0]      alu_b;
  logic                 lt_s;
  logic                 lt_u;
  logic                 cmp_exp;
  logic [XLEN-1:0]      alu_exp;

  // Multiplier reference with operands widened to 64 bits per op signedness
  logic [2*XLEN-1:0]    ext_a;
  logic [2*XLEN-1:0]    ext_b;
  logic [2*XLEN-1:0]    prod;
  logic                 mult_start;
  logic [XLEN-1:0]      mult_exp;
  logic                 high_q;
  logic [XLEN-1:0]      hi_q;

  // Stage handshake and ports
  logic                 free_exp;
  logic                 ready_exp;
  logic                 valid_exp;
  logic [XLEN-1:0]      fw_exp;
  rf_port_t             fw_port_exp;
  rf_port_t             wb_port_exp;
  logic                 wb_we_q;
  logic [RF_ADDR_W-1:0] wb_waddr_q;

  //////////////////////////////////////////////////
  // ALU rules
  //////////////////////////////////////////////////

  assign alu_a = alu_req_i.operand_a;
  assign alu_b = alu_req_i.operand_b;
  assign lt_s  = ($signed(alu_a) < $signed(alu_b));
  assign lt_u  = (alu_a < alu_b);

  always_comb begin
    case (alu_req_i.op)
      ALU_EQ:  cmp_exp = (alu_a == alu_b);
      ALU_NE:  cmp_exp = (alu_a != alu_b);
      ALU_LT:  cmp_exp = lt_s;
      ALU_GE:  cmp_exp = !lt_s;
      ALU_LTU: cmp_exp = lt_u;
      ALU_GEU: cmp_exp = !lt_u;
      default: cmp_exp = 1'b0;
    endcase
    case (alu_req_i.op)
      ALU_ADD:  alu_exp = alu_a + alu_b;
      ALU_SUB:  alu_exp = alu_a - alu_b;
      ALU_XOR:  alu_exp = alu_a ^ alu_b;
      ALU_OR:   alu_exp = alu_a | alu_b;
      ALU_AND:  alu_exp = alu_a & alu_b;
      ALU_SLL:  alu_exp = alu_a << alu_b[SHAMT_W-1:0];
      ALU_SRL:  alu_exp = alu_a >> alu_b[SHAMT_W-1:0];
      ALU_SRA:  alu_exp = $unsigned($signed(alu_a) >>> alu_b[SHAMT_W-1:0]);
      ALU_SLT:  alu_exp = {{(XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: alu_exp = {{(XLEN-1){1'b0}}, lt_u};
      default:  alu_exp = {{(XLEN-1){1'b0}}, cmp_exp};
    endcase
  end

  //////////////////////////////////////////////////
  // Multiplier, handshake and port rules
  //////////////////////////////////////////////////

  // Operand a is signed for H and HSU, operand b only for H
  assign ext_a = (mult_req_i.op == MUL_H || mult_req_i.op == MUL_HSU) ?
                 {{XLEN{sign_bit(mult_req_i.operand_a)}}, mult_req_i.operand_a} :
                 {{XLEN{1'b0}}, mult_req_i.operand_a};
  assign ext_b = (mult_req_i.op == MUL_H) ?
                 {{XLEN{sign_bit(mult_req_i.operand_b)}}, mult_req_i.operand_b} :
                 {{XLEN{1'b0}}, mult_req_i.operand_b};
  assign prod  = ext_a * ext_b;

  assign mult_start = !high_q && mult_req_i.en && (mult_req_i.op != MUL_LO);
  assign mult_exp   = high_q ? hi_q : prod[XLEN-1:0];

  assign free_exp  = !mult_start && lsu_ready_ex_i && wb_ready_i;
  assign ready_exp = free_exp || branch_in_ex_i;
  assign valid_exp = free_exp &&
                     (alu_req_i.en || mult_req_i.en || csr_access_i || lsu_en_i);

  // CSR first, then multiplier, then ALU
  assign fw_exp = csr_access_i ? csr_rdata_i :
                  mult_req_i.en ? mult_exp :
                  alu_req_i.en ? alu_exp : '0;

  assign fw_port_exp = '{we: regfile_alu_we_i, waddr: regfile_alu_waddr_i, wdata: fw_exp};
  assign wb_port_exp = '{we: wb_we_q, waddr: wb_waddr_q, wdata: lsu_rdata_i};

  // Sign bit of an operand
  function automatic logic sign_bit(input logic [XLEN-1:0] value);
    return value[XLEN-1];
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      high_q     <= 1'b0;
      hi_q       <= '0;
      wb_we_q    <= 1'b0;
      wb_waddr_q <= '0;
    end else begin
      if (mult_start) begin
        high_q <= 1'b1;
        hi_q   <= prod[2*XLEN-1:XLEN];
      end else if (high_q && ready_exp) begin
        high_q <= 1'b0;
      end
      if (valid_exp) begin
        wb_we_q <= regfile_we_i;
        if (regfile_we_i) begin
          wb_waddr_q <= regfile_waddr_i;
        end
      end else if (wb_ready_i) begin
        wb_we_q <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  a_fw_port: assert property (@(posedge clk) disable iff (!rst_n)
    regfile_alu_fw_o == fw_port_exp) else begin
    fail_count++;
    $error("MISMATCH regfile_alu_fw_o got %h exp %h",
           $sampled(regfile_alu_fw_o), $sampled(fw_port_exp));
  end

  a_branch: assert property (@(posedge clk) disable iff (!rst_n)
    branch_decision_o == cmp_exp) else begin
    fail_count++;
    $error("MISMATCH branch_decision_o got %h exp %h",
           $sampled(branch_decision_o), $sampled(cmp_exp));
  end

  a_jump: assert property (@(posedge clk) disable iff (!rst_n)
    jump_target_o == alu_req_i.operand_c) else begin
    fail_count++;
    $error("MISMATCH jump_target_o got %h exp %h",
           $sampled(jump_target_o), $sampled(alu_req_i.operand_c));
  end

  a_ready: assert property (@(posedge clk) disable iff (!rst_n)
    ex_ready_o == ready_exp) else begin
    fail_count++;
    $error("MISMATCH ex_ready_o got %h exp %h", $sampled(ex_ready_o), $sampled(ready_exp));
  end

  a_valid: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_o == valid_exp) else begin
    fail_count++;
    $error("MISMATCH ex_valid_o got %h exp %h", $sampled(ex_valid_o), $sampled(valid_exp));
  end

  // High half shows for as long as the stage is held
  a_multicycle: assert property (@(posedge clk) disable iff (!rst_n)
    mult_multicycle_o == high_q) else begin
    fail_count++;
    $error("MISMATCH mult_multicycle_o got %h exp %h",
           $sampled(mult_multicycle_o), $sampled(high_q));
  end

  a_wb_port: assert property (@(posedge clk) disable iff (!rst_n)
    regfile_wb_o == wb_port_exp) else begin
    fail_count++;
    $error("MISMATCH regfile_wb_o got %h exp %h",
           $sampled(regfile_wb_o), $sampled(wb_port_exp));
  end

  // State seen while reset is held
  a_reset_state: assert property (@(posedge clk)
    !rst_n |-> (!regfile_wb_o.we && regfile_wb_o.waddr == '0 && !mult_multicycle_o)) else begin
    fail_count++;
    $error("MISMATCH reset state we %h waddr %h mult_multicycle_o %h",
           $sampled(regfile_wb_o.we), $sampled(regfile_wb_o.waddr), $sampled(mult_multicycle_o));
  end

endmodule

bind ex_stage ex_stage_properties u_props (.*);

`default_nettype wire

//--- dv/tb_clock_gen.sv
// Free-running 8 ns clock from time zero; reset is held low for the first five rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);
  localparam int unsigned HALF_PERIOD_NS = 4;
  localparam int unsigned RESET_CYCLES   = 5;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- source/ex_stage.sv
// Execute stage top; ID must keep its requests stable while ex_ready_o is low
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
  input  logic                         clk,
  input  logic                         rst_n,
  // Requests from ID
  input  ex_pkg::alu_req_t             alu_req_i,
  input  ex_pkg::mult_req_t            mult_req_i,
  input  logic                         csr_access_i,
  input  logic                         lsu_en_i,
  input  logic [ex_pkg::XLEN-1:0]      csr_rdata_i,
  input  logic [ex_pkg::XLEN-1:0]      lsu_rdata_i,
  input  logic                         regfile_alu_we_i,
  input  logic [ex_pkg::RF_ADDR_W-1:0] regfile_alu_waddr_i,
  input  logic                         regfile_we_i,
  input  logic [ex_pkg::RF_ADDR_W-1:0] regfile_waddr_i,
  // Stall control
  input  logic                         branch_in_ex_i,
  input  logic                         lsu_ready_ex_i,
  input  logic                         wb_ready_i,
  // Register file ports
  output ex_pkg::rf_port_t             regfile_alu_fw_o,
  output ex_pkg::rf_port_t             regfile_wb_o,
  // To IF
  output logic [ex_pkg::XLEN-1:0]      jump_target_o,
  output logic                         branch_decision_o,
  output logic                         mult_multicycle_o,
  output logic                         ex_ready_o,
  output logic                         ex_valid_o
);
  import ex_pkg::*;

  logic [XLEN-1:0] alu_result;
  logic            alu_cmp_result;
  logic [XLEN-1:0] mult_result;
  logic            mult_ready;

  // Branch target and decision
  assign jump_target_o     = alu_req_i.operand_c;
  assign branch_decision_o = alu_cmp_result;

  //////////////////////////////////////////////////
  // Units
  //////////////////////////////////////////////////

  ex_alu u_alu (
    .req_i        (alu_req_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  // Multiplier releases its high half on stage ready
  ex_mult u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (mult_req_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  //////////////////////////////////////////////////
  // Write-back and handshake
  //////////////////////////////////////////////////

  ex_writeback_ctrl u_wb_ctrl (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_en_i            (alu_req_i.en),
    .mult_en_i           (mult_req_i.en),
    .csr_access_i        (csr_access_i),
    .lsu_en_i            (lsu_en_i),
    .alu_result_i        (alu_result),
    .mult_result_i       (mult_result),
    .csr_rdata_i         (csr_rdata_i),
    .lsu_rdata_i         (lsu_rdata_i),
    .regfile_alu_we_i    (regfile_alu_we_i),
    .regfile_alu_waddr_i (regfile_alu_waddr_i),
    .regfile_we_i        (regfile_we_i),
    .regfile_waddr_i     (regfile_waddr_i),
    .mult_ready_i        (mult_ready),
    .lsu_ready_ex_i      (lsu_ready_ex_i),
    .wb_ready_i          (wb_ready_i),
    .branch_in_ex_i      (branch_in_ex_i),
    .alu_fw_o            (regfile_alu_fw_o),
    .wb_o                (regfile_wb_o),
    .ex_ready_o          (ex_ready_o),
    .ex_valid_o          (ex_valid_o)
  );

endmodule

`default_nettype wire

//--- source/ex_writeback_ctrl.sv
// Forwarding mux is combinational; the load write-back port lags one cycle and ready/valid are levels
`timescale 1ns/1ps
`default_nettype none

module ex_writeback_ctrl (
  input  logic                         clk,
  input  logic                         rst_n,
  // Unit enables
  input  logic                         alu_en_i,
  input  logic                         mult_en_i,
  input  logic                         csr_access_i,
  input  logic                         lsu_en_i,
  // Unit results
  input  logic [ex_pkg::XLEN-1:0]      alu_result_i,
  input  logic [ex_pkg::XLEN-1:0]      mult_result_i,
  input  logic [ex_pkg::XLEN-1:0]      csr_rdata_i,
  input  logic [ex_pkg::XLEN-1:0]      lsu_rdata_i,
  // Destination registers from ID
  input  logic                         regfile_alu_we_i,
  input  logic [ex_pkg::RF_ADDR_W-1:0] regfile_alu_waddr_i,
  input  logic                         regfile_we_i,
  input  logic [ex_pkg::RF_ADDR_W-1:0] regfile_waddr_i,
  // Stall sources
  input  logic                         mult_ready_i,
  input  logic                         lsu_ready_ex_i,
  input  logic                         wb_ready_i,
  input  logic                         branch_in_ex_i,
  // Write ports
  output ex_pkg::rf_port_t             alu_fw_o,
  output ex_pkg::rf_port_t             wb_o,
  // Stage handshake levels
  output logic                         ex_ready_o,
  output logic                         ex_valid_o
);
  import ex_pkg::*;

  // EX/WB register for the load port
  logic                 wb_we_q;
  logic [RF_ADDR_W-1:0] wb_waddr_q;

  // No unit is holding the stage
  logic                 not_stalled;
  logic                 any_en;

  //////////////////////////////////////////////////
  // Forwarding port
  //////////////////////////////////////////////////

  // CSR wins over multiplier, multiplier over ALU
  always_comb begin
    alu_fw_o.we    = regfile_alu_we_i;
    alu_fw_o.waddr = regfile_alu_waddr_i;
    if (csr_access_i) begin
      alu_fw_o.wdata = csr_rdata_i;
    end else if (mult_en_i) begin
      alu_fw_o.wdata = mult_result_i;
    end else if (alu_en_i) begin
      alu_fw_o.wdata = alu_result_i;
    end else begin
      alu_fw_o.wdata = '0;
    end
  end

  //////////////////////////////////////////////////
  // Stall logic
  //////////////////////////////////////////////////

  assign not_stalled = mult_ready_i & lsu_ready_ex_i & wb_ready_i;
  assign any_en      = alu_en_i | mult_en_i | csr_access_i | lsu_en_i;

  // Valid goes forward only, so it ignores the branch term
  assign ex_valid_o  = any_en & not_stalled;
  // A branch resolves here and never waits on WB
  assign ex_ready_o  = not_stalled | branch_in_ex_i;

  //////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_we_q    <= 1'b0;
      wb_waddr_q <= '0;
    end else if (ex_valid_o) begin
      // wb_ready_i is already part of ex_valid_o
      wb_we_q <= regfile_we_i;
      if (regfile_we_i) begin
        wb_waddr_q <= regfile_waddr_i;
      end
    end else if (wb_ready_i) begin
      // Bubble, flush the previous write
      wb_we_q <= 1'b0;
    end
  end

  // Load data arrives straight from the LSU in the WB cycle
  assign wb_o.we    = wb_we_q;
  assign wb_o.waddr = wb_waddr_q;
  assign wb_o.wdata = lsu_rdata_i;

endmodule

`default_nettype wire

//--- source/ex_mult.sv
// One multiply in flight; high-half ops need one extra cycle and the request must be held meanwhile
`timescale 1ns/1ps
`default_nettype none

module ex_mult (
  input  logic                    clk,
  input  logic                    rst_n,
  input  ex_pkg::mult_req_t       req_i,
  input  logic                    ex_ready_i,
  output logic [ex_pkg::XLEN-1:0] result_o,
  output logic                    ready_o,
  output logic                    multicycle_o
);
  import ex_pkg::*;

  // Sequencer states
  typedef enum logic {
    MUL_IDLE,
    MUL_HIGH
  } mult_state_e;

  mult_state_e         state_q;
  mult_state_e         state_d;

  // Operand sign handling
  logic                sign_a;
  logic                sign_b;
  // Operands extended to the product width
  logic [2*XLEN-1:0]   mul_a;
  logic [2*XLEN-1:0]   mul_b;
  // Low 64 bits of the full product
  logic [2*XLEN-1:0]   product;

  // High half captured for the second cycle
  logic [XLEN-1:0]     prod_hi_q;
  logic                start_high;

  //////////////////////////////////////////////////
  // Signed multiplier core
  //////////////////////////////////////////////////

  // MUL_LO ignores signedness since the low half is the same either way
  always_comb begin
    case (req_i.op)
      MUL_H:   begin
        sign_a = 1'b1;
        sign_b = 1'b1;
      end
      MUL_HSU: begin
        sign_a = 1'b1;
        sign_b = 1'b0;
      end
      default: begin
        sign_a = 1'b0;
        sign_b = 1'b0;
      end
    endcase
  end

  // Extend to 64 bits with sign or zero per operand
  assign mul_a   = {{XLEN{sign_a & req_i.operand_a[XLEN-1]}}, req_i.operand_a};
  assign mul_b   = {{XLEN{sign_b & req_i.operand_b[XLEN-1]}}, req_i.operand_b};
  assign product = mul_a * mul_b;

  //////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////

  // A high op seen in idle starts the extra cycle
  assign start_high = (state_q == MUL_IDLE) && req_i.en && (req_i.op != MUL_LO);

  always_comb begin
    state_d = state_q;
    case (state_q)
      MUL_IDLE: if (start_high) state_d = MUL_HIGH;
      // Hold the high half until the stage moves on
      MUL_HIGH: if (ex_ready_i) state_d = MUL_IDLE;
      default:  state_d = MUL_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MUL_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture the high half as the high op starts
  always_ff @(posedge clk) begin
    if (start_high) begin
      prod_hi_q <= product[2*XLEN-1:XLEN];
    end
  end

  // Outputs
  assign ready_o      = ~start_high;
  assign multicycle_o = (state_q == MUL_HIGH);
  assign result_o     = (state_q == MUL_HIGH) ? prod_hi_q : product[XLEN-1:0];

endmodule

`default_nettype wire

//--- source/ex_alu.sv
// Purely combinational ALU; cmp_result_o is only meaningful for the six branch comparison ops
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
  input  ex_pkg::alu_req_t        req_i,
  output logic [ex_pkg::XLEN-1:0] result_o,
  output logic                    cmp_result_o
);
  import ex_pkg::*;

  // Operand aliases
  logic [XLEN-1:0]    op_a;
  logic [XLEN-1:0]    op_b;
  logic [SHAMT_W-1:0] shamt;

  // Adder and shared subtractor
  logic [XLEN-1:0]    sum;
  logic [XLEN:0]      diff;

  // Comparison terms
  logic               is_equal;
  logic               less_signed;
  logic               less_unsigned;

  // Shifter outputs
  logic [XLEN-1:0]    shift_left;
  logic [XLEN-1:0]    shift_right;
  logic [XLEN-1:0]    shift_arith;

  assign op_a  = req_i.operand_a;
  assign op_b  = req_i.operand_b;
  assign shamt = op_b[SHAMT_W-1:0];

  //////////////////////////////////////////////////
  // Arithmetic
  //////////////////////////////////////////////////

  assign sum  = op_a + op_b;
  // One extra bit so the top bit is the unsigned borrow
  assign diff = {1'b0, op_a} - {1'b0, op_b};

  //////////////////////////////////////////////////
  // Comparisons
  //////////////////////////////////////////////////

  assign is_equal      = (op_a == op_b);
  // Borrow out means a < b unsigned
  assign less_unsigned = diff[XLEN];
  // Sign bits differ: the negative one is smaller
  // Otherwise the subtraction cannot overflow and its sign decides
  assign less_signed   = (op_a[XLEN-1] ^ op_b[XLEN-1]) ? op_a[XLEN-1] : diff[XLEN-1];

  //////////////////////////////////////////////////
  // Shifts
  //////////////////////////////////////////////////

  assign shift_left  = op_a << shamt;
  assign shift_right = op_a >> shamt;
  assign shift_arith = $unsigned($signed(op_a) >>> shamt);

  // Branch comparison bit
  always_comb begin
    case (req_i.op)
      ALU_EQ:  cmp_result_o = is_equal;
      ALU_NE:  cmp_result_o = ~is_equal;
      ALU_LT:  cmp_result_o = less_signed;
      ALU_GE:  cmp_result_o = ~less_signed;
      ALU_LTU: cmp_result_o = less_unsigned;
      ALU_GEU: cmp_result_o = ~less_unsigned;
      // Non-compare ops never signal a taken branch
      default: cmp_result_o = 1'b0;
    endcase
  end

  // Result mux
  always_comb begin
    case (req_i.op)
      ALU_ADD:  result_o = sum;
      ALU_SUB:  result_o = diff[XLEN-1:0];
      ALU_XOR:  result_o = op_a ^ op_b;
      ALU_OR:   result_o = op_a | op_b;
      ALU_AND:  result_o = op_a & op_b;
      ALU_SLL:  result_o = shift_left;
      ALU_SRL:  result_o = shift_right;
      ALU_SRA:  result_o = shift_arith;
      // Set-less-than, zero-extended flag
      ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, less_signed};
      ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, less_unsigned};
      // Branch ops return the comparison bit zero-extended
      default:  result_o = {{(XLEN-1){1'b0}}, cmp_result_o};
    endcase
  end

endmodule

`default_nettype wire

//--- source/ex_pkg.sv
// Shared types for the execute stage; XLEN is fixed at 32 and the enums cover only RV32IM ops
`default_nettype none

package ex_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Data path width
  localparam int unsigned XLEN      = 32;
  // Register file address, 64 entries (integer and CSR-mapped)
  localparam int unsigned RF_ADDR_W = 6;
  // Shift amount taken from the low bits of operand b
  localparam int unsigned SHAMT_W   = 5;

  //////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////

  // ALU operations, the last six are branch comparisons
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  // Multiplier operations
  // Only MUL_LO completes in the same cycle
  typedef enum logic [1:0] {
    MUL_LO,
    MUL_H,
    MUL_HSU,
    MUL_HU
  } mult_op_e;

  //////////////////////////////////////////////////
  // Port structs
  //////////////////////////////////////////////////

  // ALU request from ID, operand_c carries the jump target
  typedef struct packed {
    logic            en;
    alu_op_e         op;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] operand_c;
  } alu_req_t;

  // Multiplier request from ID
  typedef struct packed {
    logic            en;
    mult_op_e        op;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
  } mult_req_t;

  // Register file write port
  typedef struct packed {
    logic                 we;
    logic [RF_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]      wdata;
  } rf_port_t;

endpackage

`default_nettype wire
